//--- design/bpb_macros.svh
`ifndef BPB_MACROS_SVH
`define BPB_MACROS_SVH

// number of lines in the direct-mapped buffer, must stay a power of two
`define BPB_ENTRIES 16

// log2 of the entry count
`define BPB_INDEX_WIDTH 4

// pc bits above the index, with the two byte-offset bits dropped
`define BPB_TAG_WIDTH (32 - 2 - `BPB_INDEX_WIDTH)

// index field starts right above the word offset
`define BPB_INDEX_LSB 2

`endif

//--- design/bpb_pkg.sv
package bpb_pkg;

    // fetch address or branch target
    typedef logic [31:0] word_t;

    // per-slot prediction as seen by the fetch stage
    typedef struct packed {
        logic  taken;
        word_t destpc;
    } bpb_result_t;

    // 2-bit counter, the upper bit is the prediction
    typedef enum logic [1:0] {
        strong_not   = 2'b00,
        weak_up      = 2'b01,
        weak_down    = 2'b10,
        strong_taken = 2'b11
    } bpb_state_t;

endpackage

//--- design/bpb_if.sv
`timescale 1ns/1ps

// combinational lookup path between the fetch steer and the table
interface bpb_lookup_if
    import bpb_pkg::*;
();
    word_t       [1:0] slot_pc;
    logic        [1:0] hit;
    bpb_result_t [1:0] result;

    modport steer (
        output slot_pc,
        input  hit,
        input  result
    );

    // the name table is a reserved word, hence tbl
    modport tbl (
        input  slot_pc,
        output hit,
        output result
    );
endinterface

// resolved branch coming back from the core
interface bpb_commit_if
    import bpb_pkg::*;
();
    logic  wen;   // single-cycle strobe
    word_t pc;
    logic  taken;
    word_t destpc;

    modport source (output wen, output pc, output taken, output destpc);

    modport sink (input wen, input pc, input taken, input destpc);
endinterface

//--- design/bpb_line.sv
`timescale 1ns/1ps

`include "bpb_macros.svh"

module bpb_line
    import bpb_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  word_t       [1:0] slot_pc,
    output logic        [1:0] hit,
    output bpb_result_t [1:0] result,
    bpb_commit_if.sink        commit
);

    logic                      valid;
    logic [`BPB_TAG_WIDTH-1:0] tag;
    word_t                     destpc;
    bpb_state_t                state;

    logic [`BPB_TAG_WIDTH-1:0] commit_tag;
    logic                      update;
    logic                      alloc;
    bpb_state_t                base_state;
    bpb_state_t                next_state;

    assign commit_tag = commit.pc[31 -: `BPB_TAG_WIDTH];
    assign update     = commit.wen && !stall;   // wen already carries the line select
    assign alloc      = !valid || (tag != commit_tag);

    // a fresh entry starts from weak_up and takes the transition in the same cycle
    assign base_state = alloc ? weak_up : state;

    always_comb
    begin
        case (base_state)
            strong_not:   next_state = commit.taken ? weak_up : strong_not;
            weak_up:      next_state = commit.taken ? strong_taken : strong_not;
            weak_down:    next_state = commit.taken ? strong_taken : strong_not;
            strong_taken: next_state = commit.taken ? strong_taken : weak_down;
            default:      next_state = strong_not;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            valid <= 1'b0;
            state <= strong_not;
        end
        else if (update)
        begin
            valid <= 1'b1;
            state <= next_state;
        end
    end

    // tag and target are only written when the line changes owner
    always_ff @(posedge clk)
    begin
        if (update && alloc)
        begin
            tag    <= commit_tag;
            destpc <= commit.destpc;
        end
    end

    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            hit[s]           = valid && (tag == slot_pc[s][31 -: `BPB_TAG_WIDTH]);
            result[s].taken  = hit[s] && state[1];
            result[s].destpc = destpc;
        end
    end

endmodule

//--- design/bpb_table.sv
`timescale 1ns/1ps

`include "bpb_macros.svh"

module bpb_table
    import bpb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    bpb_lookup_if.tbl  lookup,
    bpb_commit_if.sink commit
);

    logic [`BPB_INDEX_WIDTH-1:0] commit_index;
    logic [`BPB_ENTRIES-1:0]     line_sel;

    // per-line answers for both slots, muxed down by the slot index below
    logic        [1:0] line_hit    [`BPB_ENTRIES];
    bpb_result_t [1:0] line_result [`BPB_ENTRIES];

    logic [`BPB_INDEX_WIDTH-1:0] slot_index [2];

    assign commit_index = commit.pc[`BPB_INDEX_LSB +: `BPB_INDEX_WIDTH];

    // one-hot select so a commit writes exactly one line
    always_comb
    begin
        line_sel = '0;
        line_sel[commit_index] = 1'b1;
    end

    for (genvar i = 0; i < `BPB_ENTRIES; i++)
    begin : g_line
        bpb_commit_if line_commit ();

        assign line_commit.wen    = commit.wen && line_sel[i];
        assign line_commit.pc     = commit.pc;
        assign line_commit.taken  = commit.taken;
        assign line_commit.destpc = commit.destpc;

        bpb_line line_i (
            .clk     (clk),
            .reset   (reset),
            .stall   (stall),
            .slot_pc (lookup.slot_pc),
            .hit     (line_hit[i]),
            .result  (line_result[i]),
            .commit  (line_commit.sink)
        );
    end

    // the two slots may land on different lines
    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            slot_index[s] = lookup.slot_pc[s][`BPB_INDEX_LSB +: `BPB_INDEX_WIDTH];
        end
    end

    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            lookup.hit[s]    = line_hit[slot_index[s]][s];
            lookup.result[s] = line_result[slot_index[s]][s];   // tag already checked in the line
        end
    end

endmodule

//--- design/bpb_fetch_steer.sv
`timescale 1ns/1ps

module bpb_fetch_steer
    import bpb_pkg::*;
(
    input  word_t        fetch_pc,
    bpb_lookup_if.steer  lookup,
    output word_t        next_pc,
    output logic  [1:0]  taken_slot
);

    logic  [1:0] slot_taken;
    word_t       seq_pc;

    // a fetch covers two instructions
    assign lookup.slot_pc[0] = fetch_pc;
    assign lookup.slot_pc[1] = fetch_pc + 32'd4;

    assign seq_pc = fetch_pc + 32'd8;   // fall-through past both slots

    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            slot_taken[s] = lookup.hit[s] && lookup.result[s].taken;
        end
    end

    // slot 0 is older, so it wins when both predict taken
    always_comb
    begin
        if (slot_taken[0])
        begin
            next_pc    = lookup.result[0].destpc;
            taken_slot = 2'b01;
        end
        else if (slot_taken[1])
        begin
            next_pc    = lookup.result[1].destpc;
            taken_slot = 2'b10;
        end
        else
        begin
            next_pc    = seq_pc;
            taken_slot = 2'b00;
        end
    end

endmodule

//--- design/bpb_top.sv
`timescale 1ns/1ps

module bpb_top
    import bpb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,

    input  word_t      fetch_pc,
    output logic [1:0] pred_hit,
    output logic [1:0] pred_taken,
    output word_t      pred_target0,
    output word_t      pred_target1,
    output word_t      next_pc,
    output logic [1:0] taken_slot,

    input  logic       commit_wen,
    input  logic       commit_taken,
    input  word_t      commit_pc,
    input  word_t      commit_target
);

    bpb_lookup_if lookup_bus ();
    bpb_commit_if commit_bus ();

    assign commit_bus.wen    = commit_wen;
    assign commit_bus.pc     = commit_pc;
    assign commit_bus.taken  = commit_taken;
    assign commit_bus.destpc = commit_target;

    bpb_fetch_steer steer_i (
        .fetch_pc   (fetch_pc),
        .lookup     (lookup_bus.steer),
        .next_pc    (next_pc),
        .taken_slot (taken_slot)
    );

    bpb_table table_i (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .lookup (lookup_bus.tbl),
        .commit (commit_bus.sink)
    );

    // per-slot view for the fetch stage
    assign pred_hit        = lookup_bus.hit;
    assign pred_taken[0]   = lookup_bus.result[0].taken;
    assign pred_taken[1]   = lookup_bus.result[1].taken;
    assign pred_target0    = lookup_bus.result[0].destpc;
    assign pred_target1    = lookup_bus.result[1].destpc;

endmodule

//--- bench/bpb_checker.sv
`timescale 1ns/1ps

`include "bpb_macros.svh"

module bpb_checker
    import bpb_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       stall,
    input word_t      fetch_pc,
    input logic [1:0] pred_hit,
    input logic [1:0] pred_taken,
    input word_t      pred_target0,
    input word_t      pred_target1,
    input word_t      next_pc,
    input logic [1:0] taken_slot,
    input logic       commit_wen,
    input logic       commit_taken,
    input word_t      commit_pc,
    input word_t      commit_target
);

    // shadow copy of the buffer, rebuilt from the commits seen at the ports
    logic                        sh_valid  [`BPB_ENTRIES];
    logic [`BPB_TAG_WIDTH-1:0]   sh_tag    [`BPB_ENTRIES];
    word_t                       sh_target [`BPB_ENTRIES];
    bpb_state_t                  sh_count  [`BPB_ENTRIES];

    logic [`BPB_INDEX_WIDTH-1:0] commit_index;
    logic [`BPB_TAG_WIDTH-1:0]   commit_tag;

    word_t [1:0] slot_pc;
    logic  [1:0] exp_hit;
    logic  [1:0] exp_taken;
    word_t [1:0] exp_target;
    word_t       exp_next;
    logic  [1:0] exp_slot;

    logic fail_hit    = 1'b0;
    logic fail_taken  = 1'b0;
    logic fail_target = 1'b0;
    logic fail_steer  = 1'b0;
    logic fail_stall  = 1'b0;
    logic failed;   // sticky, polled by the testbench

    function automatic logic [`BPB_INDEX_WIDTH-1:0] index_of(input word_t pc);
        return pc[`BPB_INDEX_LSB +: `BPB_INDEX_WIDTH];
    endfunction

    function automatic logic [`BPB_TAG_WIDTH-1:0] tag_of(input word_t pc);
        return pc[31 -: `BPB_TAG_WIDTH];
    endfunction

    // saturating walk 00 -> 01 -> 11, with 11 backing off to 10 and 10 dropping to 00
    function automatic bpb_state_t count_after(input bpb_state_t cnt, input logic taken);
        case (cnt)
            strong_not:   return taken ? weak_up : strong_not;
            weak_up:      return taken ? strong_taken : strong_not;
            strong_taken: return taken ? strong_taken : weak_down;
            default:      return taken ? strong_taken : strong_not;
        endcase
    endfunction

    assign commit_index = index_of(commit_pc);
    assign commit_tag   = tag_of(commit_pc);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < `BPB_ENTRIES; i++)
            begin
                sh_valid[i] <= 1'b0;
            end
        end
        else if (commit_wen && !stall)
        begin
            if (!sh_valid[commit_index] || (sh_tag[commit_index] != commit_tag))
            begin
                sh_valid[commit_index]  <= 1'b1;
                sh_tag[commit_index]    <= commit_tag;
                sh_target[commit_index] <= commit_target;
                sh_count[commit_index]  <= count_after(weak_up, commit_taken);   // seeded entry
            end
            else
            begin
                sh_count[commit_index] <= count_after(sh_count[commit_index], commit_taken);
            end
        end
    end

    always_comb
    begin
        slot_pc[0] = fetch_pc;
        slot_pc[1] = fetch_pc + 32'd4;
        for (int s = 0; s < 2; s++)
        begin
            exp_hit[s]    = sh_valid[index_of(slot_pc[s])]
                            && (sh_tag[index_of(slot_pc[s])] == tag_of(slot_pc[s]));
            exp_taken[s]  = exp_hit[s] && sh_count[index_of(slot_pc[s])][1];
            exp_target[s] = sh_target[index_of(slot_pc[s])];
        end
        exp_next = exp_taken[0] ? exp_target[0] : exp_taken[1] ? exp_target[1] : fetch_pc + 32'd8;
        exp_slot = exp_taken[0] ? 2'b01 : exp_taken[1] ? 2'b10 : 2'b00;
    end

    assign failed = fail_hit | fail_taken | fail_target | fail_steer | fail_stall;

    a_hit: assert property (@(posedge clk) disable iff (!reset) pred_hit == exp_hit)
    else
    begin
        fail_hit = 1'b1;
        $error("pred_hit %b, shadow table expects %b", pred_hit, exp_hit);
    end

    a_taken: assert property (@(posedge clk) disable iff (!reset) pred_taken == exp_taken)
    else
    begin
        fail_taken = 1'b1;
        $error("pred_taken %b, shadow table expects %b", pred_taken, exp_taken);
    end

    // a missing slot may show any stale target
    a_target: assert property (@(posedge clk) disable iff (!reset)
        (!exp_hit[0] || pred_target0 == exp_target[0])
        && (!exp_hit[1] || pred_target1 == exp_target[1]))
    else
    begin
        fail_target = 1'b1;
        $error("targets %h %h, shadow table expects %h %h",
               pred_target0, pred_target1, exp_target[0], exp_target[1]);
    end

    a_steer: assert property (@(posedge clk) disable iff (!reset)
        next_pc == exp_next && taken_slot == exp_slot)
    else
    begin
        fail_steer = 1'b1;
        $error("next_pc %h slot %b, expected %h slot %b", next_pc, taken_slot, exp_next, exp_slot);
    end

    // a commit dropped by stall leaves the predictions of an unchanged fetch as they were
    a_stall: assert property (@(posedge clk) disable iff (!reset)
        (stall && commit_wen) |=>
            (!$stable(fetch_pc) || ($stable(pred_hit) && $stable(pred_taken))))
    else
    begin
        fail_stall = 1'b1;
        $error("prediction changed after a stalled commit");
    end

endmodule

bind bpb_top bpb_checker checker_i (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .fetch_pc      (fetch_pc),
    .pred_hit      (pred_hit),
    .pred_taken    (pred_taken),
    .pred_target0  (pred_target0),
    .pred_target1  (pred_target1),
    .next_pc       (next_pc),
    .taken_slot    (taken_slot),
    .commit_wen    (commit_wen),
    .commit_taken  (commit_taken),
    .commit_pc     (commit_pc),
    .commit_target (commit_target)
);

//--- bench/bpb_tb.sv
`timescale 1ns/1ps

`include "bpb_macros.svh"

module bpb_tb
    import bpb_pkg::*;
();

    localparam int RESET_CYCLES    = 16;
    localparam int HIT_TIMEOUT     = 8;
    localparam int RANDOM_CYCLES   = 600;
    localparam int WATCHDOG_CYCLES = 5000;

    logic       clk;
    logic       reset;
    logic       stall;
    word_t      fetch_pc;
    logic [1:0] pred_hit;
    logic [1:0] pred_taken;
    word_t      pred_target0;
    word_t      pred_target1;
    word_t      next_pc;
    logic [1:0] taken_slot;
    logic       commit_wen;
    logic       commit_taken;
    word_t      commit_pc;
    word_t      commit_target;

    logic [15:0] lfsr = 16'd48235;
    word_t       pc_a;
    word_t       pc_b;
    word_t       pc_c;

    bpb_top dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    // taps for x^16 + x^14 + x^13 + x^11 with one step per bit handed out
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // four indices times two tags, so lines get fought over
    function automatic word_t pool_pc(input logic [2:0] sel);
        logic [`BPB_INDEX_WIDTH-1:0] idx;
        logic [`BPB_TAG_WIDTH-1:0]   tag;
        case (sel[1:0])
            2'd0:    idx = 4'd4;
            2'd1:    idx = 4'd5;
            2'd2:    idx = 4'd6;
            default: idx = 4'd11;
        endcase
        tag = sel[2] ? 26'h2b7e410 : 26'h15a3c01;
        return {tag, idx, 2'b00};
    endfunction

    task automatic commit_branch(input word_t pc, input logic taken, input word_t target,
                                 input logic stalled);
        commit_wen    = 1'b1;
        commit_pc     = pc;
        commit_taken  = taken;
        commit_target = target;
        stall         = stalled;
        fetch_pc      = pc;   // look the branch up while it commits
        @(negedge clk);
        commit_wen = 1'b0;
        stall      = 1'b0;
    endtask

    task automatic train(input word_t pc, input logic taken, input word_t target, input int n);
        for (int i = 0; i < n; i++)
        begin
            commit_branch(pc, taken, target, 1'b0);
        end
    endtask

    task automatic hold_fetch(input word_t pc, input int cycles);
        fetch_pc = pc;
        for (int c = 0; c < cycles; c++)
        begin
            @(negedge clk);
        end
    endtask

    // fetch_pc already points at the committed branch
    task automatic wait_for_hit(input word_t pc);
        int waited;
        waited = 0;
        while (!pred_hit[0] && waited < HIT_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!pred_hit[0])
            stop_with_failure($sformatf("no hit for committed branch at %h", pc));
    endtask

    always @(negedge clk)
    begin
        if (dut_i.checker_i.failed)
            stop_with_failure($sformatf("ERR @ %0d ns: checker assertion failed", $time));
    end

    initial
    begin
        for (int c = 0; c < WATCHDOG_CYCLES; c++)
        begin
            @(posedge clk);
        end
        stop_with_failure("watchdog expired before the test sequence finished");
    end

    initial
    begin
        stall         = 1'b0;
        fetch_pc      = '0;
        commit_wen    = 1'b0;
        commit_taken  = 1'b0;
        commit_pc     = '0;
        commit_target = '0;
        reset         = 1'b0;
        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(negedge clk);
        end
        reset = 1'b1;

        // every fetch falls through while the buffer is empty
        for (int c = 0; c < 8; c++)
        begin
            fetch_pc = random_bits(32);
            @(negedge clk);
        end

        pc_a = pool_pc(3'd3);
        pc_b = pool_pc(3'd7);   // same index under the other tag
        commit_branch(pc_a, 1'b1, 32'h0040_1200, 1'b0);
        wait_for_hit(pc_a);
        commit_branch(pc_b, 1'b0, 32'h0040_3400, 1'b0);
        wait_for_hit(pc_b);
        hold_fetch(pc_a, 2);
        commit_branch(pc_a, 1'b0, 32'h0040_5600, 1'b0);
        wait_for_hit(pc_a);

        // back-to-back walk through 11 10 00 01 11 10
        pc_c = pool_pc(3'd6);
        commit_branch(pc_c, 1'b1, 32'h0080_0040, 1'b0);
        train(pc_c, 1'b0, 32'h0080_0040, 2);
        train(pc_c, 1'b1, 32'h0080_0040, 2);
        commit_branch(pc_c, 1'b0, 32'h0080_0040, 1'b0);
        hold_fetch(pc_c, 2);

        commit_branch(pool_pc(3'd2), 1'b1, 32'h0090_0000, 1'b1);
        hold_fetch(pool_pc(3'd2), 2);
        commit_branch(pc_c, 1'b0, 32'h0080_0040, 1'b1);   // would drop 10 to 00
        hold_fetch(pc_c, 2);

        pc_a = pool_pc(3'd0);
        pc_b = pc_a + 32'd4;
        commit_branch(pc_a, 1'b1, 32'h00a0_0100, 1'b0);
        commit_branch(pc_b, 1'b1, 32'h00a0_0200, 1'b0);
        hold_fetch(pc_a, 2);                             // both taken
        train(pc_a, 1'b0, 32'h00a0_0100, 2);
        hold_fetch(pc_a, 2);                             // slot 1 only
        train(pc_a, 1'b1, 32'h00a0_0100, 2);
        train(pc_b, 1'b0, 32'h00a0_0200, 2);
        hold_fetch(pc_a, 2);                             // slot 0 only
        train(pc_a, 1'b0, 32'h00a0_0100, 2);
        hold_fetch(pc_a, 2);                             // neither

        for (int n = 0; n < RANDOM_CYCLES; n++)
        begin
            commit_wen    = (random_bits(2) != 0);
            stall         = (random_bits(3) == 0);
            commit_pc     = pool_pc(3'(random_bits(3)));
            commit_taken  = 1'(random_bits(1));
            commit_target = {30'(random_bits(30)), 2'b00};
            fetch_pc      = (random_bits(1) != 0) ? pool_pc(3'(random_bits(3)))
                                                  : pool_pc(3'(random_bits(3))) + 32'd4;
            @(negedge clk);
        end
        commit_wen = 1'b0;
        stall      = 1'b0;
        hold_fetch(pc_a, 2);

        if (dut_i.checker_i.failed)
            stop_with_failure($sformatf("ERR @ %0d ns: checker assertion failed", $time));
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- all.f
+incdir+design
design/bpb_pkg.sv
design/bpb_if.sv
design/bpb_line.sv
design/bpb_table.sv
design/bpb_fetch_steer.sv
design/bpb_top.sv
bench/bpb_checker.sv
bench/bpb_tb.sv

//--- Makefile
VERILATOR    ?= verilator
TOP          := bpb_tb
FILELIST     := all.f
BUILD_DIR    := obj_dir
LOG          := sim.log
FAIL_MSG     := Simulation failed

COMMON_FLAGS := --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS   := --lint-only
BUILD_FLAGS  := --binary -j 0 --Mdir $(BUILD_DIR)
RUN_FLAGS    := +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

sim:
	$(VERILATOR) $(BUILD_FLAGS) $(COMMON_FLAGS)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
